// File: hw/fetch_pkg.sv
//**************************************************************************
// Fetch front end shared types
// Address and line widths, cache refill states, memory request
//**************************************************************************

package fetch_pkg;

   // Byte address of the fetch and memory side
   localparam int ADDR_W = 16;

   // One instruction word
   localparam int INSTR_W = 16;

   // Cache line, four instructions
   localparam int LINE_W = 64;

   // Byte offset inside a line
   localparam int OFFSET_W = 3;

   // Cache refill sequencing
   typedef enum logic [1:0] {
      IDLE,      // Serving hits, watching for a miss
      REFILL,    // Line read out to memory, waiting on mem_rdy
      FILL_DONE  // Line just written, settle one cycle
   } refill_state_e;

   // Line read toward external memory
   // addr is line aligned, low OFFSET_W bits zero
   typedef struct packed {
      logic              valid; // Level, held until mem_rdy
      logic [ADDR_W-1:0] addr;  // Line base address
   } mem_req_t;

endpackage

// File: hw/icache_if.sv
//**************************************************************************
// Fetch to instruction cache link, request and hit response
//**************************************************************************

`timescale 1ns/100ps

interface icache_if;
   import fetch_pkg::*;

   logic               req_valid; // Fetch wants an instruction
   logic [ADDR_W-1:0]  req_addr;  // Byte address, always the PC
   logic               res_rdy;   // Addressed line present
   logic [INSTR_W-1:0] res_data;  // Instruction, valid with res_rdy

   // Fetch side, owns the request
   modport fetch (
      output req_valid,
      output req_addr,
      input  res_rdy,
      input  res_data
   );

   // Cache side, answers combinationally from its line registers
   modport cache (
      input  req_valid,
      input  req_addr,
      output res_rdy,
      output res_data
   );

endinterface

// File: hw/fetch_unit.sv
//**************************************************************************
// Fetch unit
// Program counter with branch select, hazard and miss hold, valid masking
//**************************************************************************

`timescale 1ns/100ps

module fetch_unit (
   input  logic                          clk,
   input  logic                          rst,

   input  logic                          data_hazard, // Decode cannot take more
   input  logic                          pc_hazard,   // Control hazard in flight
   input  logic                          pc_src,      // Take the branch target
   input  logic [fetch_pkg::ADDR_W-1:0]  pc_branch,   // Branch target, byte address

   icache_if.fetch                       bus,

   output logic [fetch_pkg::ADDR_W-1:0]  pc,
   output logic [fetch_pkg::INSTR_W-1:0] instr,
   output logic                          instr_valid,
   output logic                          pc_hazard_ff // pc_hazard one cycle late
);
   import fetch_pkg::*;

   logic [ADDR_W-1:0] pc_plus_2; // Sequential step
   logic [ADDR_W-1:0] pc_next;   // Selected next PC
   logic              hazard;    // Either stall source
   logic              pc_load;   // PC takes pc_next this edge
   logic              fetch_en;  // Requests start one cycle out of reset

   // Stall from decode or from an unresolved branch
   assign hazard = data_hazard | pc_hazard;

   // Next PC select
   always_comb begin
      pc_plus_2 = pc + ADDR_W'(2);
      if (pc_src) begin
         pc_next = pc_branch; // Redirect
      end else begin
         pc_next = pc_plus_2;
      end
   end

   // Advance only once the current instruction is out of the cache
   // A branch still loads under a hazard, never under a miss
   assign pc_load = bus.res_rdy & (pc_src | ~hazard);

   always_ff @(posedge clk) begin
      if (rst) begin
         pc           <= '0;
         pc_hazard_ff <= 1'b0;
         fetch_en     <= 1'b0;
      end else begin
         pc_hazard_ff <= pc_hazard; // Every edge, no hold
         fetch_en     <= 1'b1;
         if (pc_load) begin
            pc <= pc_next;
         end
      end
   end

   // Request follows the PC, so a held PC asks for nothing new
   assign bus.req_valid = fetch_en;
   assign bus.req_addr  = pc;

   // Drop the word while a branch is unresolved or just resolved
   // and while the line is still missing
   assign instr_valid = bus.res_rdy & ~pc_hazard & ~pc_hazard_ff;

   // Zero when not valid, decode keys off instr_valid
   always_comb begin
      if (instr_valid) begin
         instr = bus.res_data;
      end else begin
         instr = '0;
      end
   end

   // Instructions are halfword aligned; an odd target from execute is a bug
   a_pc_even: assert property (@(posedge clk) disable iff (rst)
      !pc[0])
      else $error("fetch_unit: pc is odd (%h)", pc);

endmodule

// File: hw/icache.sv
//**************************************************************************
// Direct-mapped instruction cache
// 64-bit lines, refill from external memory on a miss
//**************************************************************************

`timescale 1ns/100ps

module icache #(
   parameter int NUM_LINES = 16 // Power of two
) (
   input  logic                         clk,
   input  logic                         rst,

   icache_if.cache                      bus,

   output fetch_pkg::mem_req_t          mem_req,  // Line read, level
   input  logic                         mem_rdy,  // One-cycle strobe with data
   input  logic [fetch_pkg::LINE_W-1:0] mem_data  // Whole line
);
   import fetch_pkg::*;

   localparam int INDEX_W = $clog2(NUM_LINES);
   localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;
   localparam int WORD_W  = OFFSET_W - 1; // Halfword select inside a line

   // Line storage
   logic [LINE_W-1:0]    line_data [NUM_LINES];
   logic [TAG_W-1:0]     line_tag  [NUM_LINES];
   logic [NUM_LINES-1:0] line_valid;

   refill_state_e        state;

   // Outstanding memory read
   logic                 rd_valid;
   logic [ADDR_W-1:0]    rd_addr;

   // Request address split
   logic [INDEX_W-1:0]   req_index;
   logic [TAG_W-1:0]     req_tag;
   logic [WORD_W-1:0]    req_word;

   // Refill target, taken from the held read address
   logic [INDEX_W-1:0]   fill_index;
   logic [TAG_W-1:0]     fill_tag;

   logic                 hit;
   logic                 miss;

   assign req_index  = bus.req_addr[OFFSET_W +: INDEX_W];
   assign req_tag    = bus.req_addr[ADDR_W-1 -: TAG_W];
   assign req_word   = bus.req_addr[OFFSET_W-1:1]; // Bits 2:1

   assign fill_index = rd_addr[OFFSET_W +: INDEX_W];
   assign fill_tag   = rd_addr[ADDR_W-1 -: TAG_W];

   // Tag compare at the request index
   assign hit  = bus.req_valid & line_valid[req_index]
                 & (line_tag[req_index] == req_tag);
   assign miss = bus.req_valid & ~hit;

   // Response straight off the line registers
   assign bus.res_rdy  = hit;
   assign bus.res_data = line_data[req_index][req_word*INSTR_W +: INSTR_W];

   // Refill control
   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= IDLE;
         rd_valid   <= 1'b0;
         line_valid <= '0; // Cold cache
      end else begin
         unique case (state)
            IDLE: begin
               if (miss) begin
                  state    <= REFILL;
                  rd_valid <= 1'b1; // Up next cycle
               end
            end
            REFILL: begin
               if (mem_rdy) begin
                  state                  <= FILL_DONE;
                  rd_valid               <= 1'b0;
                  line_valid[fill_index] <= 1'b1; // Hit from next cycle
               end
            end
            FILL_DONE: begin
               state <= IDLE; // Line now hits, no new miss this cycle
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // Payload, no reset
   always_ff @(posedge clk) begin
      if (state == IDLE && miss) begin
         // Line aligned read address
         rd_addr <= {bus.req_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
      end
      if (state == REFILL && mem_rdy) begin
         line_data[fill_index] <= mem_data;
         line_tag[fill_index]  <= fill_tag; // Evicts whatever sat here
      end
   end

   always_comb begin
      mem_req.valid = rd_valid;
      mem_req.addr  = rd_addr;
   end

   // Memory sees a steady request until it answers
   a_req_stable: assert property (@(posedge clk) disable iff (rst)
      mem_req.valid && !mem_rdy |=> mem_req.valid && $stable(mem_req.addr))
      else $error("icache: memory request changed before mem_rdy");

   // Fetch holds its PC through a miss, so nothing can hit mid-refill
   a_no_hit_in_refill: assert property (@(posedge clk) disable iff (rst)
      state == REFILL |-> !bus.res_rdy)
      else $error("icache: res_rdy high during REFILL");

endmodule

// File: hw/fetch_top.sv
//**************************************************************************
// Fetch front end top, fetch unit over a direct-mapped instruction cache
//**************************************************************************

`timescale 1ns/100ps

module fetch_top #(
   parameter int NUM_LINES = 16 // Cache lines, power of two
) (
   input  logic                          clk,
   input  logic                          rst,

   // From decode and execute
   input  logic                          data_hazard,
   input  logic                          pc_hazard,
   input  logic                          pc_src,
   input  logic [fetch_pkg::ADDR_W-1:0]  pc_branch,

   // Refill memory answer
   input  logic                          mem_rdy,
   input  logic [fetch_pkg::LINE_W-1:0]  mem_data,

   // Toward decode
   output logic [fetch_pkg::ADDR_W-1:0]  pc,
   output logic [fetch_pkg::INSTR_W-1:0] instr,
   output logic                          instr_valid,
   output logic                          pc_hazard_ff,

   // Refill memory request
   output logic                          mem_req_valid,
   output logic [fetch_pkg::ADDR_W-1:0]  mem_req_addr
);
   import fetch_pkg::*;

   mem_req_t mem_req;

   icache_if i_bus ();

   fetch_unit i_fetch (
      .clk          (clk),
      .rst          (rst),
      .data_hazard  (data_hazard),
      .pc_hazard    (pc_hazard),
      .pc_src       (pc_src),
      .pc_branch    (pc_branch),
      .bus          (i_bus.fetch),
      .pc           (pc),
      .instr        (instr),
      .instr_valid  (instr_valid),
      .pc_hazard_ff (pc_hazard_ff)
   );

   icache #(
      .NUM_LINES (NUM_LINES)
   ) i_cache (
      .clk      (clk),
      .rst      (rst),
      .bus      (i_bus.cache),
      .mem_req  (mem_req),
      .mem_rdy  (mem_rdy),
      .mem_data (mem_data)
   );

   // Flatten the request for the memory port
   assign mem_req_valid = mem_req.valid;
   assign mem_req_addr  = mem_req.addr;

endmodule

// File: verif/tb_fetch_mem.sv
//**************************************************************************
// Refill memory model, line reads answered after a pseudo-random delay
//**************************************************************************

`timescale 1ns/100ps

module tb_fetch_mem #(
   parameter int MIN_DELAY = 1 // Cycles added to the 2-bit random part
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          mem_req_valid,
   input  logic [fetch_pkg::ADDR_W-1:0]  mem_req_addr,
   output logic                          mem_rdy,    // One-cycle strobe
   output logic [fetch_pkg::LINE_W-1:0]  mem_data,
   output logic [15:0]                   req_count,  // Requests taken so far
   output logic [fetch_pkg::ADDR_W-1:0]  last_addr   // Address of the latest request
);
   import fetch_pkg::*;

   localparam int WORD_AW = ADDR_W - 1; // Halfword index width

   logic [INSTR_W-1:0] image [1 << WORD_AW]; // Whole address space, halfwords
   logic [31:0]        lfsr;
   logic               busy;
   logic [2:0]         wait_cnt;
   logic [1:0]         delay_bits;
   logic [WORD_AW-1:0] word_base;

   // Galois LFSR, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      if (state[0]) begin
         return (state >> 1) ^ 32'h8020_0003;
      end else begin
         return state >> 1;
      end
   endfunction

   initial begin
      // Word at byte address a holds a ^ 5A00
      for (int i = 0; i < (1 << WORD_AW); i++) begin
         image[i] = INSTR_W'(2 * i) ^ 16'h5A00;
      end
      mem_rdy   = 1'b0;
      mem_data  = '0;
      req_count = '0;
      last_addr = '0;
      busy      = 1'b0;
      wait_cnt  = '0;
      lfsr      = 32'h145;
      forever begin
         @(posedge clk);
         #1; // Drive just after the edge
         if (rst) begin
            mem_rdy   = 1'b0;
            busy      = 1'b0;
            req_count = '0;
         end else if (mem_rdy) begin
            mem_rdy = 1'b0; // Request drops on this edge
         end else if (busy) begin
            wait_cnt = wait_cnt - 3'd1;
            if (wait_cnt == 3'd0) begin
               word_base = last_addr[ADDR_W-1:1];
               // Lowest address in the low bits
               mem_data  = {image[word_base + WORD_AW'(3)], image[word_base + WORD_AW'(2)],
                            image[word_base + WORD_AW'(1)], image[word_base]};
               mem_rdy   = 1'b1;
               busy      = 1'b0;
            end
         end else if (mem_req_valid) begin
            req_count     = req_count + 16'd1;
            last_addr     = mem_req_addr;
            delay_bits[0] = lfsr[0]; // One step per bit
            lfsr          = lfsr_step(lfsr);
            delay_bits[1] = lfsr[0];
            lfsr          = lfsr_step(lfsr);
            wait_cnt      = 3'(delay_bits) + 3'(MIN_DELAY);
            busy          = 1'b1;
         end
      end
   end

endmodule

// File: verif/tb_fetch.sv
//**************************************************************************
// Fetch front end testbench, table of hazards and branches against pc/instr
//**************************************************************************

`timescale 1ns/100ps

module tb_fetch;
   import fetch_pkg::*;

   localparam int NUM_LINES    = 16;
   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 16;
   localparam int WAIT_LIMIT   = 40; // Cycles per wait for instr_valid

   // One stimulus row and what the front end must show for it
   typedef struct packed {
      logic              data_hazard;
      logic              pc_hazard;
      logic              pc_src;
      logic [ADDR_W-1:0] pc_branch;
      logic              exp_valid;   // Low for rows under a PC hazard
      logic [ADDR_W-1:0] exp_pc;
      logic [15:0]       exp_refills; // Memory requests so far
   } row_t;

   row_t rows [$];

   logic               clk;
   logic               rst;
   logic               data_hazard;
   logic               pc_hazard;
   logic               pc_src;
   logic [ADDR_W-1:0]  pc_branch;
   logic               mem_rdy;
   logic [LINE_W-1:0]  mem_data;
   logic [ADDR_W-1:0]  pc;
   logic [INSTR_W-1:0] instr;
   logic               instr_valid;
   logic               pc_hazard_ff;
   logic               mem_req_valid;
   logic [ADDR_W-1:0]  mem_req_addr;
   logic [15:0]        req_count;
   logic [ADDR_W-1:0]  last_addr;
   logic [15:0]        prev_refills;
   logic               prev_pc_hazard; // pc_hazard seen at the last edge

   int errors;
   int rows_failed;

   fetch_top #(
      .NUM_LINES (NUM_LINES)
   ) i_dut (
      .clk           (clk),
      .rst           (rst),
      .data_hazard   (data_hazard),
      .pc_hazard     (pc_hazard),
      .pc_src        (pc_src),
      .pc_branch     (pc_branch),
      .mem_rdy       (mem_rdy),
      .mem_data      (mem_data),
      .pc            (pc),
      .instr         (instr),
      .instr_valid   (instr_valid),
      .pc_hazard_ff  (pc_hazard_ff),
      .mem_req_valid (mem_req_valid),
      .mem_req_addr  (mem_req_addr)
   );

   tb_fetch_mem i_mem (
      .clk           (clk),
      .rst           (rst),
      .mem_req_valid (mem_req_valid),
      .mem_req_addr  (mem_req_addr),
      .mem_rdy       (mem_rdy),
      .mem_data      (mem_data),
      .req_count     (req_count),
      .last_addr     (last_addr)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic add_row(input logic dh, input logic ph, input logic src,
                          input logic [ADDR_W-1:0] branch, input logic valid,
                          input logic [ADDR_W-1:0] exp_pc, input logic [15:0] refills);
      row_t r;
      r.data_hazard = dh;
      r.pc_hazard   = ph;
      r.pc_src      = src;
      r.pc_branch   = branch;
      r.exp_valid   = valid;
      r.exp_pc      = exp_pc;
      r.exp_refills = refills;
      rows.push_back(r);
   endtask

   // Column order is data_hazard, pc_hazard, pc_src, pc_branch, valid, pc, refills
   // Lines at 0x100 and 0x000 share index 0, 0x40 and 0xC0 share index 8
   task automatic load_table();
      add_row(1'b0, 1'b0, 1'b0, 16'h0000, 1'b1, 16'h0000, 16'd1); // Cold miss
      add_row(1'b0, 1'b0, 1'b0, 16'h0000, 1'b1, 16'h0002, 16'd1);
      add_row(1'b0, 1'b0, 1'b0, 16'h0000, 1'b1, 16'h0004, 16'd1);
      add_row(1'b0, 1'b0, 1'b0, 16'h0000, 1'b1, 16'h0006, 16'd1); // Last word of line 0
      add_row(1'b0, 1'b0, 1'b0, 16'h0000, 1'b1, 16'h0008, 16'd2); // Next line
      add_row(1'b1, 1'b0, 1'b0, 16'h0000, 1'b1, 16'h000A, 16'd2); // Data hazard holds
      add_row(1'b1, 1'b0, 1'b0, 16'h0000, 1'b1, 16'h000A, 16'd2);
      add_row(1'b0, 1'b0, 1'b0, 16'h0000, 1'b1, 16'h000A, 16'd2);
      add_row(1'b1, 1'b0, 1'b1, 16'h0100, 1'b1, 16'h000C, 16'd2); // Branch under hazard
      add_row(1'b0, 1'b0, 1'b0, 16'h0000, 1'b1, 16'h0100, 16'd3);
      add_row(1'b0, 1'b1, 1'b0, 16'h0000, 1'b0, 16'h0102, 16'd3); // PC hazard
      add_row(1'b0, 1'b1, 1'b0, 16'h0000, 1'b0, 16'h0102, 16'd3);
      add_row(1'b0, 1'b0, 1'b0, 16'h0000, 1'b0, 16'h0102, 16'd3); // Registered hazard
      add_row(1'b0, 1'b0, 1'b0, 16'h0000, 1'b1, 16'h0104, 16'd3);
      add_row(1'b0, 1'b0, 1'b1, 16'h0000, 1'b1, 16'h0106, 16'd3); // Back to 0
      add_row(1'b0, 1'b0, 1'b0, 16'h0000, 1'b1, 16'h0000, 16'd4); // Evicted by 0x100
      add_row(1'b0, 1'b0, 1'b1, 16'h0100, 1'b1, 16'h0002, 16'd4);
      add_row(1'b0, 1'b0, 1'b0, 16'h0000, 1'b1, 16'h0100, 16'd5); // Evicted by 0x000
      add_row(1'b0, 1'b1, 1'b1, 16'h0040, 1'b0, 16'h0102, 16'd5); // Branch under PC hazard
      add_row(1'b0, 1'b0, 1'b0, 16'h0000, 1'b0, 16'h0040, 16'd5);
      add_row(1'b0, 1'b0, 1'b0, 16'h0000, 1'b1, 16'h0040, 16'd6);
      add_row(1'b0, 1'b0, 1'b0, 16'h0000, 1'b1, 16'h0042, 16'd6);
      add_row(1'b0, 1'b0, 1'b1, 16'h00C0, 1'b1, 16'h0044, 16'd6);
      add_row(1'b0, 1'b0, 1'b0, 16'h0000, 1'b1, 16'h00C0, 16'd7); // Same index as 0x40
      add_row(1'b0, 1'b0, 1'b1, 16'h0046, 1'b1, 16'h00C2, 16'd7);
      add_row(1'b0, 1'b0, 1'b0, 16'h0000, 1'b1, 16'h0046, 16'd8); // Conflict refill
      add_row(1'b0, 1'b0, 1'b0, 16'h0000, 1'b1, 16'h0048, 16'd9);
   endtask

   // Sample shortly after each edge until instr_valid rises or the limit runs out
   task automatic wait_for_valid(output logic seen);
      int cycles;
      cycles = 0;
      while (!instr_valid && cycles < WAIT_LIMIT) begin
         @(posedge clk);
         #5;
         cycles++;
      end
      seen = instr_valid;
   endtask

   task automatic run_row(input int idx);
      row_t               r;
      logic               seen;
      int                 errors_before;
      logic [INSTR_W-1:0] exp_instr;
      logic [ADDR_W-1:0]  exp_line;
      r             = rows[idx];
      errors_before = errors;
      exp_instr     = r.exp_pc ^ 16'h5A00; // Memory image rule
      exp_line      = {r.exp_pc[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
      @(posedge clk);
      #1;
      data_hazard = r.data_hazard;
      pc_hazard   = r.pc_hazard;
      pc_src      = r.pc_src;
      pc_branch   = r.pc_branch;
      #4; // Let the combinational outputs settle
      // Registered copy of the previous row's pc_hazard
      assert (pc_hazard_ff == prev_pc_hazard) else begin
         $display("Error: pc_hazard_ff = %h, expected %h", pc_hazard_ff, prev_pc_hazard);
         errors++;
      end
      if (r.exp_valid) begin
         wait_for_valid(seen);
         assert (seen) else begin
            $display("Row %0d: instr_valid did not rise within %0d cycles", idx, WAIT_LIMIT);
            errors++;
         end
         if (seen) begin
            assert (instr == exp_instr) else begin
               $display("Error: instr = %h, expected %h", instr, exp_instr);
               errors++;
            end
            assert (req_count == r.exp_refills) else begin
               $display("Error: req_count = %h, expected %h", req_count, r.exp_refills);
               errors++;
            end
            // A new line was read, so the last request must be its base
            if (r.exp_refills != prev_refills) begin
               assert (last_addr == exp_line) else begin
                  $display("Error: mem_req_addr = %h, expected %h", last_addr, exp_line);
                  errors++;
               end
            end
         end
         prev_refills = r.exp_refills;
      end else begin
         assert (!instr_valid) else begin
            $display("Error: instr_valid = %h, expected %h", instr_valid, 1'b0);
            errors++;
         end
      end
      assert (pc == r.exp_pc) else begin
         $display("Error: pc = %h, expected %h", pc, r.exp_pc);
         errors++;
      end
      prev_pc_hazard = r.pc_hazard;
      if (errors == errors_before) begin
         $display("Row %0d pc %h valid %0d: passed", idx, r.exp_pc, r.exp_valid);
      end else begin
         $display("Row %0d pc %h valid %0d: FAILED", idx, r.exp_pc, r.exp_valid);
         rows_failed++;
      end
   endtask

   initial begin
      rst            = 1'b1;
      data_hazard    = 1'b0;
      pc_hazard      = 1'b0;
      pc_src         = 1'b0;
      pc_branch      = '0;
      prev_refills   = '0;
      prev_pc_hazard = 1'b0;
      errors         = 0;
      rows_failed    = 0;
      load_table();
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;
      for (int i = 0; i < rows.size(); i++) begin
         run_row(i);
      end
      $display("Rows run %0d, passed %0d, failed %0d, check errors %0d",
               rows.size(), rows.size() - rows_failed, rows_failed, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: filelist.f
hw/fetch_pkg.sv
hw/icache_if.sv
hw/fetch_unit.sv
hw/icache.sv
hw/fetch_top.sv
verif/tb_fetch_mem.sv
verif/tb_fetch.sv

// File: Makefile
# Verilator build and run for the fetch front end

SIM      = verilator
TOP      = tb_fetch
FILELIST = filelist.f
FLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
